// File: Bender.yml
package:
  name: biu_wb_resp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/wb_resp_pkg.sv
      - verilog/biu_responder_wb.sv
      - verilog/biu_latency_regs.sv
      - verilog/biu_sram_target.sv
      - verilog/biu_wb_top.sv
      - target: test
        files:
          - bench/tb_biu_wb_top.sv

// File: bench/tb_biu_wb_top.sv
// ##########################################################################
// Testbench for the Wishbone responder subsystem
// Classic and burst Wishbone driver tasks with ack timeouts
// Memory and register model with byte-select merge
// Beat latency checks against the programmed wait count
// ##########################################################################

`include "wb_resp_macros.svh"

module tb_biu_wb_top;
    timeunit 1ns;
    timeprecision 1ps;

    import wb_resp_pkg::*;

    localparam int          DW          = `WB_DATA_WIDTH;
    localparam int          SW          = `W2S(`WB_DATA_WIDTH);
    localparam int          ACK_TIMEOUT = 32;
    localparam logic [31:0] REG_BASE    = `WB_BASE_ADDR + 32'h400;

    logic                      clk;
    logic                      rst_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    wb_cti_t                   wb_cti;
    wb_bte_t                   wb_bte;
    logic [SW-1:0]             wb_sel;
    logic [`WB_ADDR_WIDTH-1:0] wb_addr;
    logic [DW-1:0]             wb_wdata;
    logic [DW-1:0]             wb_rdata;
    logic                      wb_ack;

    // Reference model of SRAM and registers
    logic [DW-1:0] mem_model [`SRAM_WORDS];
    logic [DW-1:0] scratch_model;
    logic [2:0]    wait_model;

    // Per-beat storage of the last burst
    logic [DW-1:0] burst_wdata [8];
    logic [DW-1:0] burst_rdata [8];
    int            burst_cycles [8];

    integer seed;
    int     check_errors;
    int     timeout_errors;

    biu_wb_top UUT (
        .i_wb_clk  (clk),
        .i_rst_n   (rst_n),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_cti  (wb_cti),
        .i_wb_bte  (wb_bte),
        .i_wb_sel  (wb_sel),
        .i_wb_addr (wb_addr),
        .i_wb_data (wb_wdata),
        .o_wb_data (wb_rdata),
        .o_wb_ack  (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                               input string msg);
        if (actual !== expected) begin
            check_errors++;
            $display("CHECK FAILED time=%0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
        end
    endtask

    // Selected lanes take the new byte and the rest keep the old one
    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_val,
                                                  input logic [DW-1:0] new_val,
                                                  input logic [SW-1:0] sel);
        logic [DW-1:0] res;
        res = old_val;
        for (int b = 0; b < SW; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [DW-1:0] expected_reg(input reg_idx_t r);
        case (r)
            REG_WAIT:    return {{(DW-3){1'b0}}, wait_model};
            REG_SCRATCH: return scratch_model;
            default:     return `RESP_ID;
        endcase
    endfunction

    // One beat with cycles counted from stb to ack
    // Ack sampled on the falling edge
    task automatic drive_beat(input logic we, input wb_cti_t cti, input logic [31:0] addr,
                              input logic [SW-1:0] sel, input logic [DW-1:0] wdata,
                              output logic [DW-1:0] rdata, output int cycles);
        bit got_ack;
        got_ack = 1'b0;
        cycles  = 0;
        rdata   = '0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_cti   <= cti;
        // BTE is don't care for the responder
        wb_bte   <= wb_bte_t'(2'($random(seed)));
        wb_sel   <= sel;
        wb_addr  <= addr;
        wb_wdata <= wdata;
        while (!got_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (wb_ack) begin
                got_ack = 1'b1;
                rdata   = wb_rdata;
            end
        end
        if (!got_ack) begin
            timeout_errors++;
            $display("Ack never arrived within %0d cycles for address %h", ACK_TIMEOUT, addr);
            cycles = -1;
        end
    endtask

    // Ack is a single-cycle pulse and stays low once stb drops
    task automatic release_bus();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        wb_cti <= WB_CTI_CLASSIC;
        @(negedge clk);
        check_value(wb_ack, 1'b0, "ack after stb dropped");
    endtask

    task automatic wb_single(input logic we, input logic [31:0] addr, input logic [SW-1:0] sel,
                             input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                             output int cycles);
        drive_beat(we, WB_CTI_CLASSIC, addr, sel, wdata, rdata, cycles);
        release_bus();
    endtask

    // Incrementing burst with the last beat flagged end of burst
    task automatic wb_burst(input logic we, input int start_idx, input int len,
                            input logic [SW-1:0] sel);
        wb_cti_t cti;
        for (int i = 0; i < len; i++) begin
            cti = (i == len - 1) ? WB_CTI_END_OF_BURST : WB_CTI_INCREMENTING;
            drive_beat(we, cti, `WB_BASE_ADDR + 32'(4 * (start_idx + i)), sel,
                       burst_wdata[i], burst_rdata[i], burst_cycles[i]);
        end
        release_bus();
    endtask

    task automatic sram_write(input int idx, input logic [SW-1:0] sel, input logic [DW-1:0] data);
        logic [DW-1:0] rd;
        int            cyc;
        wb_single(1'b1, `WB_BASE_ADDR + 32'(4 * idx), sel, data, rd, cyc);
        check_value(cyc, wait_model + 1, "classic SRAM write latency");
        mem_model[idx] = merge_bytes(mem_model[idx], data, sel);
    endtask

    task automatic sram_read(input int idx);
        logic [DW-1:0] rd;
        int            cyc;
        wb_single(1'b0, `WB_BASE_ADDR + 32'(4 * idx), '1, '0, rd, cyc);
        check_value(cyc, wait_model + 1, "classic SRAM read latency");
        check_value(rd, mem_model[idx], "SRAM read data");
    endtask

    task automatic reg_write(input reg_idx_t r, input logic [SW-1:0] sel,
                             input logic [DW-1:0] data);
        logic [DW-1:0] rd;
        int            cyc;
        wb_single(1'b1, REG_BASE + 32'(4 * r), sel, data, rd, cyc);
        // Old wait count still governs this beat
        check_value(cyc, wait_model + 1, "register write latency");
        if (r == REG_WAIT && sel[0]) begin
            wait_model = data[2:0];
        end else if (r == REG_SCRATCH) begin
            scratch_model = merge_bytes(scratch_model, data, sel);
        end
    endtask

    task automatic reg_read(input reg_idx_t r, output logic [DW-1:0] rd);
        int cyc;
        wb_single(1'b0, REG_BASE + 32'(4 * r), '1, '0, rd, cyc);
        check_value(cyc, wait_model + 1, "register read latency");
    endtask

    initial begin
        logic [DW-1:0] rd;
        int            len;
        int            start;
        seed           = 32'h33d47b8f;
        check_errors   = 0;
        timeout_errors = 0;
        wait_model     = 3'(`WAIT_RESET);
        scratch_model  = '0;
        rst_n    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_cti   <= WB_CTI_CLASSIC;
        wb_bte   <= WB_BTE_LINEAR;
        wb_sel   <= '0;
        wb_addr  <= '0;
        wb_wdata <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // No ack on an idle bus after reset
        repeat (4) begin
            @(negedge clk);
            check_value(wb_ack, 1'b0, "ack while stb low");
        end
        reg_read(REG_WAIT, rd);
        check_value(rd, `WAIT_RESET, "REG_WAIT reset value");
        reg_read(REG_ID, rd);
        check_value(rd, `RESP_ID, "REG_ID value");

        // Fill pattern spread over the whole word index
        for (int i = 0; i < `SRAM_WORDS; i++) begin
            sram_write(i, '1, 32'h9e37_79b9 * 32'(i + 1));
        end

        // Random byte-enabled writes then random reads
        for (int i = 0; i < 40; i++) begin
            sram_write({$random(seed)} % `SRAM_WORDS, SW'($random(seed)), $random(seed));
        end
        for (int i = 0; i < 60; i++) begin
            sram_read({$random(seed)} % `SRAM_WORDS);
        end

        // Programmed latency on classic beats
        for (int i = 0; i < 12; i++) begin
            reg_write(REG_WAIT, '1, $random(seed));
            reg_read(REG_WAIT, rd);
            check_value(rd, expected_reg(REG_WAIT), "REG_WAIT readback");
            sram_read({$random(seed)} % `SRAM_WORDS);
            sram_write({$random(seed)} % `SRAM_WORDS, SW'($random(seed)), $random(seed));
        end

        // Bursts where only the first beat pays the wait states
        for (int n = 0; n < 8; n++) begin
            reg_write(REG_WAIT, '1, $random(seed));
            len   = 2 + ({$random(seed)} % 7);
            start = {$random(seed)} % (`SRAM_WORDS - 8);
            for (int i = 0; i < len; i++) begin
                burst_wdata[i] = $random(seed);
            end
            wb_burst(1'b1, start, len, '1);
            for (int i = 0; i < len; i++) begin
                check_value(burst_cycles[i], (i == 0) ? wait_model + 1 : 1,
                            "burst write latency");
                mem_model[start + i] = burst_wdata[i];
            end
            wb_burst(1'b0, start, len, '1);
            for (int i = 0; i < len; i++) begin
                check_value(burst_cycles[i], (i == 0) ? wait_model + 1 : 1,
                            "burst read latency");
                check_value(burst_rdata[i], mem_model[start + i], "burst read data");
            end
            // Closed burst brings back the full wait
            sram_read({$random(seed)} % `SRAM_WORDS);
        end

        // Scratch merge and read-only ID
        reg_write(REG_SCRATCH, '1, $random(seed));
        reg_write(REG_SCRATCH, 4'b0101, $random(seed));
        reg_read(REG_SCRATCH, rd);
        check_value(rd, expected_reg(REG_SCRATCH), "scratch merged readback");
        reg_write(REG_ID, '1, $random(seed));
        reg_read(REG_ID, rd);
        check_value(rd, `RESP_ID, "REG_ID after write");

        $display("Errors: %0d check failures, %0d ack timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: include/wb_resp_macros.svh
// ##########################################################################
// Shared constants for the Wishbone responder subsystem
// Bus and local address widths, window base address
// SRAM depth, wait count reset value, identification word
// Width to byte count helper
// ##########################################################################

`ifndef WB_RESP_MACROS_SVH
`define WB_RESP_MACROS_SVH

// Wishbone data and byte address widths
`define WB_DATA_WIDTH 32
`define WB_ADDR_WIDTH 32

// Rebased address inside the window
`define BIU_ADDR_WIDTH 12

// Window start on the Wishbone bus
`define WB_BASE_ADDR 32'h0000_8000

// SRAM depth in words
`define SRAM_WORDS 256

// Wait states applied out of reset
`define WAIT_RESET 2

// Read-only identification word
`define RESP_ID 32'h5752_0001

// Byte lanes in a data word of width w
`define W2S(w) ((w) / 8)

`endif

// File: verilog/biu_latency_regs.sv
// ##########################################################################
// Control register block of the responder window
// Wait count steering the target's beat latency
// Scratch register and read-only identification word
// Byte-select writes and combinational read mux
// ##########################################################################

`include "wb_resp_macros.svh"

module biu_latency_regs (
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,

    // Write and read port from the target
    input  logic                              i_reg_wr,
    input  wb_resp_pkg::reg_idx_t             i_reg_idx,
    input  logic [`W2S(`WB_DATA_WIDTH)-1:0]   i_reg_sel,
    input  logic [`WB_DATA_WIDTH-1:0]         i_reg_wdata,
    output logic [`WB_DATA_WIDTH-1:0]         o_reg_rdata,

    // Wait states per beat
    output logic [2:0]                        o_wait_cnt
);
    import wb_resp_pkg::*;

    localparam int NUM_BYTES = `W2S(`WB_DATA_WIDTH);

    logic [2:0]                wait_cnt;
    logic [`WB_DATA_WIDTH-1:0] scratch;

    // Wait count lives in byte lane 0
    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            wait_cnt <= 3'(`WAIT_RESET);
        end else if (i_reg_wr && (i_reg_idx == REG_WAIT) && i_reg_sel[0]) begin
            wait_cnt <= i_reg_wdata[2:0];
        end
    end

    // Scratch merges only the selected lanes
    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            scratch <= '0;
        end else if (i_reg_wr && (i_reg_idx == REG_SCRATCH)) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (i_reg_sel[b]) begin
                    scratch[8*b +: 8] <= i_reg_wdata[8*b +: 8];
                end
            end
        end
    end

    // Read mux
    // ID ignores writes, unused index reads zero
    always_comb begin
        case (i_reg_idx)
            REG_WAIT:    o_reg_rdata = {{(`WB_DATA_WIDTH-3){1'b0}}, wait_cnt};
            REG_SCRATCH: o_reg_rdata = scratch;
            REG_ID:      o_reg_rdata = `RESP_ID;
            default:     o_reg_rdata = '0;
        endcase
    end

    assign o_wait_cnt = wait_cnt;

endmodule

// File: verilog/biu_responder_wb.sv
// ##########################################################################
// Wishbone B4 responder front end
// Cycle qualification and CTI decode
// Address rebasing into the local window
// Ack and read data straight from the BIU
// ##########################################################################

`include "wb_resp_macros.svh"

module biu_responder_wb (
    // Wishbone side
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  wb_resp_pkg::wb_cti_t              i_wb_cti,
    input  wb_resp_pkg::wb_bte_t              i_wb_bte,
    input  logic [`W2S(`WB_DATA_WIDTH)-1:0]   i_wb_sel,
    input  logic [`WB_ADDR_WIDTH-1:0]         i_wb_addr,
    input  logic [`WB_DATA_WIDTH-1:0]         i_wb_data,
    output logic [`WB_DATA_WIDTH-1:0]         o_wb_data,
    output logic                              o_wb_ack,

    // BIU request side
    input  logic                              i_biu_done,
    input  logic [`WB_DATA_WIDTH-1:0]         i_biu_data,
    output logic                              o_biu_en,
    output logic                              o_biu_we,
    output logic                              o_biu_burst,
    output logic                              o_biu_eob,
    output logic [`W2S(`WB_DATA_WIDTH)-1:0]   o_biu_sel,
    output logic [`BIU_ADDR_WIDTH-1:0]        o_biu_addr,
    output logic [`WB_DATA_WIDTH-1:0]         o_biu_data
);
    import wb_resp_pkg::*;

    logic                      wb_en;
    logic [`WB_ADDR_WIDTH-1:0] wb_addr_rel;

    // Valid beat only with cyc and stb, never during reset
    assign wb_en = i_wb_cyc & i_wb_stb & i_rst_n;

    // Offset from the window base
    // Upper bits drop off since the initiator stays in the window
    assign wb_addr_rel = i_wb_addr - `WB_BASE_ADDR;

    // Request side towards the target
    assign o_biu_en    = wb_en;
    assign o_biu_we    = wb_en & i_wb_we;
    // Linear bursts only, so BTE does not change addressing
    assign o_biu_burst = (i_wb_cti == WB_CTI_INCREMENTING);
    assign o_biu_eob   = (i_wb_cti == WB_CTI_END_OF_BURST);
    assign o_biu_sel   = i_wb_sel;
    assign o_biu_addr  = wb_addr_rel[`BIU_ADDR_WIDTH-1:0];
    assign o_biu_data  = i_wb_data;

    // Response side, no added latency
    assign o_wb_ack  = i_biu_done;
    assign o_wb_data = i_biu_data;

endmodule

// File: verilog/biu_sram_target.sv
// ##########################################################################
// BIU target behind the Wishbone responder
// Memory and register space decode on address bit 10
// Wait-state down-counter and burst fast path
// Byte-enabled SRAM and read data mux
// ##########################################################################

`include "wb_resp_macros.svh"

module biu_sram_target (
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,

    // BIU request side
    input  logic                              i_biu_en,
    input  logic                              i_biu_we,
    input  logic                              i_biu_burst,
    input  logic                              i_biu_eob,
    input  logic [`W2S(`WB_DATA_WIDTH)-1:0]   i_biu_sel,
    input  logic [`BIU_ADDR_WIDTH-1:0]        i_biu_addr,
    input  logic [`WB_DATA_WIDTH-1:0]         i_biu_data,
    output logic                              o_biu_done,
    output logic [`WB_DATA_WIDTH-1:0]         o_biu_data,

    // Register block
    input  logic [`WB_DATA_WIDTH-1:0]         i_reg_rdata,
    input  logic [2:0]                        i_wait_cnt,
    output logic                              o_reg_wr,
    output wb_resp_pkg::reg_idx_t             o_reg_idx,
    output logic [`W2S(`WB_DATA_WIDTH)-1:0]   o_reg_sel,
    output logic [`WB_DATA_WIDTH-1:0]         o_reg_wdata
);
    import wb_resp_pkg::*;

    localparam int SRAM_AW   = $clog2(`SRAM_WORDS);
    localparam int NUM_BYTES = `W2S(`WB_DATA_WIDTH);

    logic [`WB_DATA_WIDTH-1:0] sram [`SRAM_WORDS];
    logic [SRAM_AW-1:0]        sram_idx;
    logic                      reg_space;
    logic                      busy;
    logic                      done;
    logic                      done_next;
    logic                      beat_start;
    logic                      burst_open;
    logic [2:0]                wait_eff;
    logic [2:0]                wait_left;

    // Bit 10 splits SRAM from registers
    assign reg_space = i_biu_addr[10];
    assign sram_idx  = i_biu_addr[SRAM_AW+1:2];

    // Done cycle blocks a restart on the same beat
    assign beat_start = i_biu_en & ~busy & ~done;

    // Open burst skips the wait states
    assign wait_eff = burst_open ? 3'd0 : i_wait_cnt;

    // Zero wait finishes one cycle after start
    assign done_next = (beat_start & (wait_eff == 3'd0)) |
                       (busy & (wait_left == 3'd0));

    // Beat sequencing
    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            wait_left <= 3'd0;
        end else begin
            done <= done_next;
            if (beat_start && (wait_eff != 3'd0)) begin
                busy      <= 1'b1;
                wait_left <= wait_eff - 3'd1;
            end else if (busy) begin
                if (wait_left == 3'd0) begin
                    busy <= 1'b0;
                end else begin
                    wait_left <= wait_left - 3'd1;
                end
            end
        end
    end

    // Burst state follows the CTI of each completed beat
    always_ff @(posedge i_wb_clk) begin
        if (!i_rst_n) begin
            burst_open <= 1'b0;
        end else if (done) begin
            burst_open <= i_biu_burst & ~i_biu_eob;
        end
    end

    // Write lands on the edge closing the done cycle
    always_ff @(posedge i_wb_clk) begin
        if (done && i_biu_we && !reg_space) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (i_biu_sel[b]) begin
                    sram[sram_idx][8*b +: 8] <= i_biu_data[8*b +: 8];
                end
            end
        end
    end

    // Register port
    assign o_reg_wr    = done & i_biu_we & reg_space;
    assign o_reg_idx   = reg_idx_t'(i_biu_addr[3:2]);
    assign o_reg_sel   = i_biu_sel;
    assign o_reg_wdata = i_biu_data;

    // Response
    assign o_biu_done = done;
    assign o_biu_data = reg_space ? i_reg_rdata : sram[sram_idx];

endmodule

// File: verilog/biu_wb_top.sv
// ##########################################################################
// Wishbone responder subsystem top level
// Responder front end, SRAM target and control registers
// ##########################################################################

`include "wb_resp_macros.svh"

module biu_wb_top (
    input  logic                              i_wb_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  wb_resp_pkg::wb_cti_t              i_wb_cti,
    input  wb_resp_pkg::wb_bte_t              i_wb_bte,
    input  logic [`W2S(`WB_DATA_WIDTH)-1:0]   i_wb_sel,
    input  logic [`WB_ADDR_WIDTH-1:0]         i_wb_addr,
    input  logic [`WB_DATA_WIDTH-1:0]         i_wb_data,
    output logic [`WB_DATA_WIDTH-1:0]         o_wb_data,
    output logic                              o_wb_ack
);
    import wb_resp_pkg::*;

    // Responder to target
    logic                            biu_en;
    logic                            biu_we;
    logic                            biu_burst;
    logic                            biu_eob;
    logic [`W2S(`WB_DATA_WIDTH)-1:0] biu_sel;
    logic [`BIU_ADDR_WIDTH-1:0]      biu_addr;
    logic [`WB_DATA_WIDTH-1:0]       biu_wdata;
    logic                            biu_done;
    logic [`WB_DATA_WIDTH-1:0]       biu_rdata;

    // Target to registers
    logic                            reg_wr;
    reg_idx_t                        reg_idx;
    logic [`W2S(`WB_DATA_WIDTH)-1:0] reg_sel;
    logic [`WB_DATA_WIDTH-1:0]       reg_wdata;
    logic [`WB_DATA_WIDTH-1:0]       reg_rdata;
    logic [2:0]                      wait_cnt;

    biu_responder_wb u_responder (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_cti    (i_wb_cti),
        .i_wb_bte    (i_wb_bte),
        .i_wb_sel    (i_wb_sel),
        .i_wb_addr   (i_wb_addr),
        .i_wb_data   (i_wb_data),
        .o_wb_data   (o_wb_data),
        .o_wb_ack    (o_wb_ack),
        .i_biu_done  (biu_done),
        .i_biu_data  (biu_rdata),
        .o_biu_en    (biu_en),
        .o_biu_we    (biu_we),
        .o_biu_burst (biu_burst),
        .o_biu_eob   (biu_eob),
        .o_biu_sel   (biu_sel),
        .o_biu_addr  (biu_addr),
        .o_biu_data  (biu_wdata)
    );

    biu_sram_target u_target (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_biu_en    (biu_en),
        .i_biu_we    (biu_we),
        .i_biu_burst (biu_burst),
        .i_biu_eob   (biu_eob),
        .i_biu_sel   (biu_sel),
        .i_biu_addr  (biu_addr),
        .i_biu_data  (biu_wdata),
        .o_biu_done  (biu_done),
        .o_biu_data  (biu_rdata),
        .i_reg_rdata (reg_rdata),
        .i_wait_cnt  (wait_cnt),
        .o_reg_wr    (reg_wr),
        .o_reg_idx   (reg_idx),
        .o_reg_sel   (reg_sel),
        .o_reg_wdata (reg_wdata)
    );

    biu_latency_regs u_regs (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_reg_wr    (reg_wr),
        .i_reg_idx   (reg_idx),
        .i_reg_sel   (reg_sel),
        .i_reg_wdata (reg_wdata),
        .o_reg_rdata (reg_rdata),
        .o_wait_cnt  (wait_cnt)
    );

endmodule

// File: verilog/wb_resp_pkg.sv
// ##########################################################################
// Wishbone responder package
// CTI and BTE encodings of Wishbone B4
// Register index encoding of the control window
// ##########################################################################

package wb_resp_pkg;

    // Cycle type identifier
    typedef enum logic [2:0] {
        WB_CTI_CLASSIC      = 3'b000,
        WB_CTI_CONSTANT     = 3'b001,
        WB_CTI_INCREMENTING = 3'b010,
        WB_CTI_END_OF_BURST = 3'b111
    } wb_cti_t;

    // Burst type extension
    // Only linear bursts are served
    typedef enum logic [1:0] {
        WB_BTE_LINEAR = 2'b00,
        WB_BTE_WRAP4  = 2'b01,
        WB_BTE_WRAP8  = 2'b10,
        WB_BTE_WRAP16 = 2'b11
    } wb_bte_t;

    // Control registers, word index above offset 0x400
    typedef enum logic [1:0] {
        REG_WAIT    = 2'd0,
        REG_SCRATCH = 2'd1,
        REG_ID      = 2'd2
    } reg_idx_t;

endpackage

// File: vlog.f
+incdir+include
verilog/wb_resp_pkg.sv
verilog/biu_responder_wb.sv
verilog/biu_latency_regs.sv
verilog/biu_sram_target.sv
verilog/biu_wb_top.sv
bench/tb_biu_wb_top.sv
